// File: vlog.f
+incdir+include
design/decode_pkg.sv
design/instr_decoder.sv
design/operand_forward.sv
design/branch_resolve.sv
design/id_ex_reg.sv
design/decode_stage.sv
verification/decode_stage_checker.sv
verification/decode_stage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module decode_stage_tb \
	-o decode_stage_sim

# the simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/decode_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
	exit 1
fi
grep -q "No errors" sim.log

// File: verification/decode_stage_tb.sv
`include "decode_settings.svh"

module decode_stage_tb;

	import decode_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int MAX_ROWS     = 32;

	logic                   clk = 1'b0;
	logic                   rst_i;
	logic [`DATA_W-1:0]     pc_i;
	logic [`DATA_W-1:0]     inst_i;
	logic [`DATA_W-1:0]     reg1_data_i;
	logic [`DATA_W-1:0]     reg2_data_i;
	logic                   ex_wreg_i;
	logic [`REG_ADDR_W-1:0] ex_wd_i;
	logic [`DATA_W-1:0]     ex_wdata_i;
	logic                   mem_wreg_i;
	logic [`REG_ADDR_W-1:0] mem_wd_i;
	logic [`DATA_W-1:0]     mem_wdata_i;
	logic                   reg1_read_o;
	logic                   reg2_read_o;
	logic [`REG_ADDR_W-1:0] reg1_addr_o;
	logic [`REG_ADDR_W-1:0] reg2_addr_o;
	logic                   branch_flag_o;
	logic [`DATA_W-1:0]     branch_target_address_o;
	alu_op_e                ex_aluop_o;
	alu_sel_e               ex_alusel_o;
	logic [`DATA_W-1:0]     ex_reg1_o;
	logic [`DATA_W-1:0]     ex_reg2_o;
	logic [`REG_ADDR_W-1:0] ex_wd_o;
	logic                   ex_wreg_o;
	logic [`DATA_W-1:0]     ex_link_addr_o;
	logic                   ex_is_in_delayslot_o;

	// stimulus columns
	logic [`DATA_W-1:0]     row_pc        [MAX_ROWS];
	logic [`DATA_W-1:0]     row_inst      [MAX_ROWS];
	logic [`DATA_W-1:0]     row_rf1       [MAX_ROWS];
	logic [`DATA_W-1:0]     row_rf2       [MAX_ROWS];
	logic                   row_ex_wreg   [MAX_ROWS];
	logic [`REG_ADDR_W-1:0] row_ex_wd     [MAX_ROWS];
	logic [`DATA_W-1:0]     row_ex_wdata  [MAX_ROWS];
	logic                   row_mem_wreg  [MAX_ROWS];
	logic [`REG_ADDR_W-1:0] row_mem_wd    [MAX_ROWS];
	logic [`DATA_W-1:0]     row_mem_wdata [MAX_ROWS];
	// expected columns, comb is {reg1 read, reg2 read, branch flag}
	logic [2:0]             row_comb      [MAX_ROWS];
	logic [`REG_ADDR_W-1:0] row_rs        [MAX_ROWS];
	logic [`REG_ADDR_W-1:0] row_rt        [MAX_ROWS];
	logic [`DATA_W-1:0]     row_target    [MAX_ROWS];
	alu_op_e                row_aluop     [MAX_ROWS];
	alu_sel_e               row_alusel    [MAX_ROWS];
	logic [`DATA_W-1:0]     row_reg1      [MAX_ROWS];
	logic [`DATA_W-1:0]     row_reg2      [MAX_ROWS];
	logic [`REG_ADDR_W-1:0] row_wd        [MAX_ROWS];
	logic                   row_wreg      [MAX_ROWS];
	logic [`DATA_W-1:0]     row_link      [MAX_ROWS];
	logic                   row_ds        [MAX_ROWS];

	int num_rows    = 0;
	int cycle_count = 0;
	int cycle_limit = RESET_CYCLES + MAX_ROWS * 2 + 20;

	decode_stage u_decode_stage (.*);

	bind decode_stage decode_stage_checker u_checker (
		.clk                  (clk),
		.rst_i                (rst_i),
		.branch_flag_i        (branch_flag_o),
		.ex_wreg_i            (ex_wreg_o),
		.ex_is_in_delayslot_i (ex_is_in_delayslot_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			stop_with_failure("timeout, the table was not finished within the cycle limit");
		end
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [`DATA_W-1:0] expected,
		input logic [`DATA_W-1:0] actual);
		assert (actual === expected) else begin
			stop_with_failure($sformatf("FAILED %s expected %h actual %h", name, expected,
				actual));
		end
	endtask

	task automatic add_row(
		input logic [`DATA_W-1:0]     pc,
		input logic [`DATA_W-1:0]     inst,
		input logic [`DATA_W-1:0]     rf1,
		input logic [`DATA_W-1:0]     rf2,
		input logic [2:0]             comb,
		input logic [`REG_ADDR_W-1:0] rs,
		input logic [`REG_ADDR_W-1:0] rt,
		input logic [`DATA_W-1:0]     target,
		input alu_op_e                aluop,
		input alu_sel_e               alusel,
		input logic [`DATA_W-1:0]     reg1,
		input logic [`DATA_W-1:0]     reg2,
		input logic [`REG_ADDR_W-1:0] wd,
		input logic                   wreg,
		input logic [`DATA_W-1:0]     link,
		input logic                   ds
	);
		row_pc[num_rows]        = pc;
		row_inst[num_rows]      = inst;
		row_rf1[num_rows]       = rf1;
		row_rf2[num_rows]       = rf2;
		row_ex_wreg[num_rows]   = 1'b0;
		row_ex_wd[num_rows]     = '0;
		row_ex_wdata[num_rows]  = '0;
		row_mem_wreg[num_rows]  = 1'b0;
		row_mem_wd[num_rows]    = '0;
		row_mem_wdata[num_rows] = '0;
		row_comb[num_rows]      = comb;
		row_rs[num_rows]        = rs;
		row_rt[num_rows]        = rt;
		row_target[num_rows]    = target;
		row_aluop[num_rows]     = aluop;
		row_alusel[num_rows]    = alusel;
		row_reg1[num_rows]      = reg1;
		row_reg2[num_rows]      = reg2;
		row_wd[num_rows]        = wd;
		row_wreg[num_rows]      = wreg;
		row_link[num_rows]      = link;
		row_ds[num_rows]        = ds;
		num_rows++;
	endtask

	// bypass inputs of the row added last
	task automatic set_bypass(input logic ex_wreg, input logic [`REG_ADDR_W-1:0] ex_wd,
		input logic [`DATA_W-1:0] ex_wdata, input logic mem_wreg,
		input logic [`REG_ADDR_W-1:0] mem_wd, input logic [`DATA_W-1:0] mem_wdata);
		row_ex_wreg[num_rows-1]   = ex_wreg;
		row_ex_wd[num_rows-1]     = ex_wd;
		row_ex_wdata[num_rows-1]  = ex_wdata;
		row_mem_wreg[num_rows-1]  = mem_wreg;
		row_mem_wd[num_rows-1]    = mem_wd;
		row_mem_wdata[num_rows-1] = mem_wdata;
	endtask

	task automatic build_table();
		// immediate forms, destination rt
		add_row(32'h0000_1000, 32'h3423_8001, 32'h0000_00f0, 32'h1111_1111,
			3'b100, 5'd1, 5'd3, 32'h0,
			ALU_OR, SEL_LOGIC, 32'h0000_00f0, 32'h0000_8001, 5'd3, 1'b1, 32'h0, 1'b0);
		add_row(32'h0000_1004, 32'h3c05_1234, 32'h0000_0000, 32'h2222_2222,
			3'b100, 5'd0, 5'd5, 32'h0,
			ALU_OR, SEL_LOGIC, 32'h0000_0000, 32'h1234_0000, 5'd5, 1'b1, 32'h0, 1'b0);
		add_row(32'h0000_1008, 32'h2046_fffc, 32'h0000_0010, 32'h3333_3333,
			3'b100, 5'd2, 5'd6, 32'h0,
			ALU_ADDI, SEL_ARITH, 32'h0000_0010, 32'hffff_fffc, 5'd6, 1'b1, 32'h0, 1'b0);
		add_row(32'h0000_100c, 32'h3887_f00f, 32'haaaa_5555, 32'h0000_0000,
			3'b100, 5'd4, 5'd7, 32'h0,
			ALU_XOR, SEL_LOGIC, 32'haaaa_5555, 32'h0000_f00f, 5'd7, 1'b1, 32'h0, 1'b0);
		add_row(32'h0000_1010, 32'h2d28_8000, 32'h0000_0007, 32'h0000_0000,
			3'b100, 5'd9, 5'd8, 32'h0,
			ALU_SLTU, SEL_ARITH, 32'h0000_0007, 32'hffff_8000, 5'd8, 1'b1, 32'h0, 1'b0);
		// shift amount arrives on reg1, rt on reg2
		add_row(32'h0000_1014, 32'h000d_6140, 32'h4444_4444, 32'h8000_0001,
			3'b010, 5'd0, 5'd13, 32'h0,
			ALU_SLL, SEL_SHIFT, 32'h0000_0005, 32'h8000_0001, 5'd12, 1'b1, 32'h0, 1'b0);
		add_row(32'h0000_1018, 32'h000f_77c3, 32'h5555_5555, 32'hf000_0000,
			3'b010, 5'd0, 5'd15, 32'h0,
			ALU_SRA, SEL_SHIFT, 32'h0000_001f, 32'hf000_0000, 5'd14, 1'b1, 32'h0, 1'b0);
		// or r3, r1, r2 under three bypass patterns
		add_row(32'h0000_101c, 32'h0022_1825, 32'h1111_0000, 32'h0000_2222,
			3'b110, 5'd1, 5'd2, 32'h0,
			ALU_OR, SEL_LOGIC, 32'he0e0_e0e0, 32'h0000_2222, 5'd3, 1'b1, 32'h0, 1'b0);
		set_bypass(1'b1, 5'd1, 32'he0e0_e0e0, 1'b1, 5'd1, 32'h3030_3030);
		add_row(32'h0000_1020, 32'h0022_1825, 32'h1111_0000, 32'h0000_2222,
			3'b110, 5'd1, 5'd2, 32'h0,
			ALU_OR, SEL_LOGIC, 32'h3030_3030, 32'h0bad_f00d, 5'd3, 1'b1, 32'h0, 1'b0);
		set_bypass(1'b1, 5'd2, 32'h0bad_f00d, 1'b1, 5'd1, 32'h3030_3030);
		add_row(32'h0000_1024, 32'h0022_1825, 32'h1111_0000, 32'h0000_2222,
			3'b110, 5'd1, 5'd2, 32'h0,
			ALU_OR, SEL_LOGIC, 32'h1111_0000, 32'h0000_2222, 5'd3, 1'b1, 32'h0, 1'b0);
		set_bypass(1'b0, 5'd1, 32'he0e0_e0e0, 1'b1, 5'd5, 32'h3030_3030);
		// conditional branches, taken ones mark the next row as delay slot
		add_row(32'h0000_2000, 32'h1022_0003, 32'h0000_0055, 32'h0000_0055,
			3'b111, 5'd1, 5'd2, 32'h2010,
			ALU_BEQ, SEL_JUMP_BRANCH, 32'h0000_0055, 32'h0000_0055, 5'd0, 1'b0, 32'h0, 1'b0);
		add_row(32'h0000_2004, 32'h1422_fffe, 32'h0000_0077, 32'h0000_0077,
			3'b110, 5'd1, 5'd2, 32'h0,
			ALU_BNE, SEL_JUMP_BRANCH, 32'h0000_0077, 32'h0000_0077, 5'd0, 1'b0, 32'h0, 1'b1);
		add_row(32'h0000_3000, 32'h0480_fffc, 32'h8000_0000, 32'h1234_5678,
			3'b101, 5'd4, 5'd0, 32'h2ff4,
			ALU_BLTZ, SEL_JUMP_BRANCH, 32'h8000_0000, 32'h0, 5'd0, 1'b0, 32'h0, 1'b0);
		add_row(32'h0000_2ff4, 32'h1ca0_0001, 32'h0000_0000, 32'h0000_0009,
			3'b100, 5'd5, 5'd0, 32'h0,
			ALU_BGTZ, SEL_JUMP_BRANCH, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b1);
		add_row(32'h0000_2ff8, 32'h18a0_0004, 32'h0000_0000, 32'h0000_0009,
			3'b101, 5'd5, 5'd0, 32'h300c,
			ALU_BLEZ, SEL_JUMP_BRANCH, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b0);
		// not taken, still links
		add_row(32'h0000_4000, 32'h04d1_0002, 32'hffff_ffff, 32'h0000_0000,
			3'b100, 5'd6, 5'd17, 32'h0,
			ALU_BGEZAL, SEL_JUMP_BRANCH, 32'hffff_ffff, 32'h0, 5'd31, 1'b1, 32'h4008, 1'b1);
		// jumps
		add_row(32'ha000_0000, 32'h0812_3456, 32'h6666_6666, 32'h7777_7777,
			3'b001, 5'd0, 5'd18, 32'ha048_d158,
			ALU_J, SEL_JUMP_BRANCH, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b0);
		add_row(32'h0040_0000, 32'h0c00_0100, 32'h0000_0000, 32'h0000_0000,
			3'b001, 5'd0, 5'd0, 32'h400,
			ALU_JAL, SEL_JUMP_BRANCH, 32'h0, 32'h0, 5'd31, 1'b1, 32'h0040_0008, 1'b1);
		add_row(32'h0000_1000, 32'h03e0_0008, 32'h0040_0008, 32'h8888_8888,
			3'b101, 5'd31, 5'd0, 32'h0040_0008,
			ALU_JR, SEL_JUMP_BRANCH, 32'h0040_0008, 32'h0, 5'd0, 1'b0, 32'h0, 1'b1);
		add_row(32'h0000_2000, 32'h0120_2009, 32'h0000_8000, 32'h9999_9999,
			3'b101, 5'd9, 5'd0, 32'h8000,
			ALU_JALR, SEL_JUMP_BRANCH, 32'h0000_8000, 32'h0, 5'd4, 1'b1, 32'h2008, 1'b1);
		add_row(32'h0000_8000, 32'h0064_1023, 32'h0000_0010, 32'h0000_0003,
			3'b110, 5'd3, 5'd4, 32'h0,
			ALU_SUBU, SEL_ARITH, 32'h0000_0010, 32'h0000_0003, 5'd2, 1'b1, 32'h0, 1'b1);
	endtask

	task automatic drive_row(input int i);
		pc_i        <= row_pc[i];
		inst_i      <= row_inst[i];
		reg1_data_i <= row_rf1[i];
		reg2_data_i <= row_rf2[i];
		ex_wreg_i   <= row_ex_wreg[i];
		ex_wd_i     <= row_ex_wd[i];
		ex_wdata_i  <= row_ex_wdata[i];
		mem_wreg_i  <= row_mem_wreg[i];
		mem_wd_i    <= row_mem_wd[i];
		mem_wdata_i <= row_mem_wdata[i];
	endtask

	task automatic check_comb(input int i);
		check_value("reg1_read_o", 32'(row_comb[i][2]), 32'(reg1_read_o));
		check_value("reg2_read_o", 32'(row_comb[i][1]), 32'(reg2_read_o));
		// an address only matters when its port is read
		if (row_comb[i][2]) begin
			check_value("reg1_addr_o", 32'(row_rs[i]), 32'(reg1_addr_o));
		end
		if (row_comb[i][1]) begin
			check_value("reg2_addr_o", 32'(row_rt[i]), 32'(reg2_addr_o));
		end
		check_value("branch_flag_o", 32'(row_comb[i][0]), 32'(branch_flag_o));
		check_value("branch_target_address_o", row_target[i], branch_target_address_o);
	endtask

	task automatic check_ex(input int i);
		check_value("ex_aluop_o", 32'(row_aluop[i]), 32'(ex_aluop_o));
		check_value("ex_alusel_o", 32'(row_alusel[i]), 32'(ex_alusel_o));
		check_value("ex_reg1_o", row_reg1[i], ex_reg1_o);
		check_value("ex_reg2_o", row_reg2[i], ex_reg2_o);
		check_value("ex_wreg_o", 32'(row_wreg[i]), 32'(ex_wreg_o));
		// destination only matters when the instruction writes
		if (row_wreg[i]) begin
			check_value("ex_wd_o", 32'(row_wd[i]), 32'(ex_wd_o));
		end
		check_value("ex_link_addr_o", row_link[i], ex_link_addr_o);
		check_value("ex_is_in_delayslot_o", 32'(row_ds[i]), 32'(ex_is_in_delayslot_o));
	endtask

	task automatic check_reset_outputs();
		check_value("reg1_read_o", 32'h0, 32'(reg1_read_o));
		check_value("reg2_read_o", 32'h0, 32'(reg2_read_o));
		check_value("reg1_addr_o", 32'h0, 32'(reg1_addr_o));
		check_value("reg2_addr_o", 32'h0, 32'(reg2_addr_o));
		check_value("branch_flag_o", 32'h0, 32'(branch_flag_o));
		check_value("ex_aluop_o", 32'(ALU_NOP), 32'(ex_aluop_o));
		check_value("ex_alusel_o", 32'(SEL_NOP), 32'(ex_alusel_o));
		check_value("ex_reg1_o", 32'h0, ex_reg1_o);
		check_value("ex_reg2_o", 32'h0, ex_reg2_o);
		check_value("ex_wd_o", 32'h0, 32'(ex_wd_o));
		check_value("ex_wreg_o", 32'h0, 32'(ex_wreg_o));
		check_value("ex_link_addr_o", 32'h0, ex_link_addr_o);
		check_value("ex_is_in_delayslot_o", 32'h0, 32'(ex_is_in_delayslot_o));
	endtask

	initial begin
		rst_i       = 1'b1;
		pc_i        = 32'h0000_0100;
		// bne r1, r2 on unequal data would read both and branch outside reset
		inst_i      = 32'h1422_0010;
		reg1_data_i = 32'hdead_beef;
		reg2_data_i = 32'hcafe_f00d;
		ex_wreg_i   = 1'b0;
		ex_wd_i     = '0;
		ex_wdata_i  = '0;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
		build_table();
		cycle_limit = RESET_CYCLES + num_rows * 2 + 20;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check_reset_outputs();
		@(posedge clk);
		rst_i <= 1'b0;
		// row i is captured one edge after it is applied
		for (int i = 0; i < num_rows; i++) begin
			drive_row(i);
			@(negedge clk);
			check_comb(i);
			if (i > 0) begin
				check_ex(i - 1);
			end
			@(posedge clk);
		end
		@(negedge clk);
		check_ex(num_rows - 1);
		$display("No errors");
		$finish;
	end

endmodule

// File: verification/decode_stage_checker.sv
module decode_stage_checker (
	input logic clk,
	input logic rst_i,
	input logic branch_flag_i,
	input logic ex_wreg_i,
	input logic ex_is_in_delayslot_i
);

	// a cleared register never requests a write
	wreg_low_after_reset: assert property (
		@(posedge clk) rst_i |=> !ex_wreg_i
	) else $error("ex_wreg_o is set in the cycle after reset");

	// flag is loaded on the branch edge and moves with the next instruction
	delayslot_follows_branch: assert property (
		@(posedge clk) disable iff (rst_i)
		ex_is_in_delayslot_i == $past(branch_flag_i, 2)
	) else $error("ex_is_in_delayslot_o does not match the branch flag two edges back");

	// decoder forces a NOP in reset
	no_branch_in_reset: assert property (
		@(posedge clk) rst_i |-> !branch_flag_i
	) else $error("branch_flag_o is high while reset is asserted");

endmodule

// File: design/decode_stage.sv
`include "decode_settings.svh"

module decode_stage (
	input  logic                                 clk,
	input  logic                                 rst_i,
	input  logic                 [`DATA_W-1:0]     pc_i,
	input  logic                 [`DATA_W-1:0]     inst_i,
	input  logic                 [`DATA_W-1:0]     reg1_data_i,
	input  logic                 [`DATA_W-1:0]     reg2_data_i,
	input  logic                                 ex_wreg_i,
	input  logic                 [`REG_ADDR_W-1:0] ex_wd_i,
	input  logic                 [`DATA_W-1:0]     ex_wdata_i,
	input  logic                                 mem_wreg_i,
	input  logic                 [`REG_ADDR_W-1:0] mem_wd_i,
	input  logic                 [`DATA_W-1:0]     mem_wdata_i,
	output logic                                 reg1_read_o,
	output logic                                 reg2_read_o,
	output logic                 [`REG_ADDR_W-1:0] reg1_addr_o,
	output logic                 [`REG_ADDR_W-1:0] reg2_addr_o,
	output logic                                 branch_flag_o,
	output logic                 [`DATA_W-1:0]     branch_target_address_o,
	output decode_pkg::alu_op_e                  ex_aluop_o,
	output decode_pkg::alu_sel_e                 ex_alusel_o,
	output logic                 [`DATA_W-1:0]     ex_reg1_o,
	output logic                 [`DATA_W-1:0]     ex_reg2_o,
	output logic                 [`REG_ADDR_W-1:0] ex_wd_o,
	output logic                                 ex_wreg_o,
	output logic                 [`DATA_W-1:0]     ex_link_addr_o,
	output logic                                 ex_is_in_delayslot_o
);

	import decode_pkg::*;

	alu_op_e                dec_aluop;
	alu_sel_e               dec_alusel;
	branch_kind_e           dec_branch_kind;
	logic [`REG_ADDR_W-1:0] dec_wd;
	logic                   dec_wreg;
	logic                   dec_link;
	logic [`DATA_W-1:0]     dec_imm;
	logic [`DATA_W-1:0]     reg1_val;
	logic [`DATA_W-1:0]     reg2_val;
	logic [`DATA_W-1:0]     link_addr;

	instr_decoder u_decoder (
		.rst_i         (rst_i),
		.inst_i        (inst_i),
		.reg1_read_o   (reg1_read_o),
		.reg2_read_o   (reg2_read_o),
		.reg1_addr_o   (reg1_addr_o),
		.reg2_addr_o   (reg2_addr_o),
		.wd_o          (dec_wd),
		.wreg_o        (dec_wreg),
		.aluop_o       (dec_aluop),
		.alusel_o      (dec_alusel),
		.imm_o         (dec_imm),
		.branch_kind_o (dec_branch_kind),
		.link_o        (dec_link)
	);

	operand_forward u_fwd1 (
		.read_i      (reg1_read_o),
		.addr_i      (reg1_addr_o),
		.reg_data_i  (reg1_data_i),
		.imm_i       (dec_imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (reg1_val)
	);

	operand_forward u_fwd2 (
		.read_i      (reg2_read_o),
		.addr_i      (reg2_addr_o),
		.reg_data_i  (reg2_data_i),
		.imm_i       (dec_imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (reg2_val)
	);

	// resolved here so fetch can redirect without a bubble
	branch_resolve u_branch (
		.pc_i                    (pc_i),
		.inst_i                  (inst_i),
		.reg1_i                  (reg1_val),
		.reg2_i                  (reg2_val),
		.branch_kind_i           (dec_branch_kind),
		.link_i                  (dec_link),
		.branch_flag_o           (branch_flag_o),
		.branch_target_address_o (branch_target_address_o),
		.link_addr_o             (link_addr)
	);

	id_ex_reg u_id_ex (
		.clk                  (clk),
		.rst_i                (rst_i),
		.aluop_i              (dec_aluop),
		.alusel_i             (dec_alusel),
		.reg1_i               (reg1_val),
		.reg2_i               (reg2_val),
		.link_addr_i          (link_addr),
		.wd_i                 (dec_wd),
		.wreg_i               (dec_wreg),
		.branch_flag_i        (branch_flag_o),
		.ex_aluop_o           (ex_aluop_o),
		.ex_alusel_o          (ex_alusel_o),
		.ex_reg1_o            (ex_reg1_o),
		.ex_reg2_o            (ex_reg2_o),
		.ex_wd_o              (ex_wd_o),
		.ex_wreg_o            (ex_wreg_o),
		.ex_link_addr_o       (ex_link_addr_o),
		.ex_is_in_delayslot_o (ex_is_in_delayslot_o)
	);

endmodule

// File: design/id_ex_reg.sv
`include "decode_settings.svh"

module id_ex_reg (
	input  logic                                 clk,
	input  logic                                 rst_i,
	input  decode_pkg::alu_op_e                  aluop_i,
	input  decode_pkg::alu_sel_e                 alusel_i,
	input  logic                 [`DATA_W-1:0]     reg1_i,
	input  logic                 [`DATA_W-1:0]     reg2_i,
	input  logic                 [`DATA_W-1:0]     link_addr_i,
	input  logic                 [`REG_ADDR_W-1:0] wd_i,
	input  logic                                 wreg_i,
	input  logic                                 branch_flag_i,
	output decode_pkg::alu_op_e                  ex_aluop_o,
	output decode_pkg::alu_sel_e                 ex_alusel_o,
	output logic                 [`DATA_W-1:0]     ex_reg1_o,
	output logic                 [`DATA_W-1:0]     ex_reg2_o,
	output logic                 [`REG_ADDR_W-1:0] ex_wd_o,
	output logic                                 ex_wreg_o,
	output logic                 [`DATA_W-1:0]     ex_link_addr_o,
	output logic                                 ex_is_in_delayslot_o
);

	import decode_pkg::*;

	// the instruction after a taken branch sits in its delay slot
	logic next_in_delayslot;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ex_aluop_o           <= ALU_NOP;
			ex_alusel_o          <= SEL_NOP;
			ex_reg1_o            <= '0;
			ex_reg2_o            <= '0;
			ex_wd_o              <= '0;
			ex_wreg_o            <= 1'b0;
			ex_link_addr_o       <= '0;
			ex_is_in_delayslot_o <= 1'b0;
			next_in_delayslot    <= 1'b0;
		end else begin
			ex_aluop_o           <= aluop_i;
			ex_alusel_o          <= alusel_i;
			ex_reg1_o            <= reg1_i;
			ex_reg2_o            <= reg2_i;
			ex_wd_o              <= wd_i;
			ex_wreg_o            <= wreg_i;
			ex_link_addr_o       <= link_addr_i;
			// flag travels with the next instruction, one edge later
			ex_is_in_delayslot_o <= next_in_delayslot;
			next_in_delayslot    <= branch_flag_i;
		end
	end

endmodule

// File: design/branch_resolve.sv
`include "decode_settings.svh"

module branch_resolve (
	input  logic                     [`DATA_W-1:0] pc_i,
	input  logic                     [`DATA_W-1:0] inst_i,
	input  logic                     [`DATA_W-1:0] reg1_i,
	input  logic                     [`DATA_W-1:0] reg2_i,
	input  decode_pkg::branch_kind_e               branch_kind_i,
	input  logic                                   link_i,
	output logic                                   branch_flag_o,
	output logic                     [`DATA_W-1:0] branch_target_address_o,
	output logic                     [`DATA_W-1:0] link_addr_o
);

	import decode_pkg::*;

	logic [`DATA_W-1:0] pc_plus_4;
	logic [`DATA_W-1:0] pc_plus_8;
	logic [`DATA_W-1:0] offset;
	logic [`DATA_W-1:0] target;
	logic               taken;
	logic               reg1_neg;
	logic               reg1_zero;

	assign pc_plus_4 = pc_i + `DATA_W'(4);
	assign pc_plus_8 = pc_i + `DATA_W'(8);

	// word offset, sign-extended
	assign offset = {{(`DATA_W-18){inst_i[15]}}, inst_i[15:0], 2'b00};

	assign reg1_neg  = reg1_i[`DATA_W-1];
	assign reg1_zero = (reg1_i == '0);

	always_comb begin
		target = pc_plus_4 + offset;
		case (branch_kind_i)
			BR_ALWAYS_IMM: begin
				taken  = 1'b1;
				// stays inside the current 256 MB region
				target = {pc_plus_4[`DATA_W-1 -: 4], inst_i[25:0], 2'b00};
			end
			BR_ALWAYS_REG: begin
				taken  = 1'b1;
				target = reg1_i;
			end
			BR_EQ: taken = (reg1_i == reg2_i);
			BR_NE: taken = (reg1_i != reg2_i);
			BR_GTZ: taken = !reg1_neg && !reg1_zero;
			BR_LEZ: taken = reg1_neg || reg1_zero;
			BR_GEZ: taken = !reg1_neg;
			BR_LTZ: taken = reg1_neg;
			default: taken = 1'b0;
		endcase
	end

	assign branch_flag_o           = taken;
	assign branch_target_address_o = taken ? target : '0;
	assign link_addr_o             = link_i ? pc_plus_8 : '0;

endmodule

// File: design/operand_forward.sv
`include "decode_settings.svh"

module operand_forward (
	input  logic                   read_i,
	input  logic [`REG_ADDR_W-1:0] addr_i,
	input  logic [`DATA_W-1:0]     reg_data_i,
	input  logic [`DATA_W-1:0]     imm_i,
	input  logic                   ex_wreg_i,
	input  logic [`REG_ADDR_W-1:0] ex_wd_i,
	input  logic [`DATA_W-1:0]     ex_wdata_i,
	input  logic                   mem_wreg_i,
	input  logic [`REG_ADDR_W-1:0] mem_wd_i,
	input  logic [`DATA_W-1:0]     mem_wdata_i,
	output logic [`DATA_W-1:0]     operand_o
);

	logic ex_hit;
	logic mem_hit;

	// r0 is not special-cased, a write to it still forwards
	assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
	assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

	// youngest result wins
	always_comb begin
		if (!read_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_wdata_i;
		end else if (mem_hit) begin
			operand_o = mem_wdata_i;
		end else begin
			operand_o = reg_data_i;
		end
	end

endmodule

// File: design/instr_decoder.sv
`include "decode_settings.svh"

module instr_decoder (
	input  logic                     rst_i,
	input  logic [`DATA_W-1:0]       inst_i,
	output logic                     reg1_read_o,
	output logic                     reg2_read_o,
	output logic [`REG_ADDR_W-1:0]   reg1_addr_o,
	output logic [`REG_ADDR_W-1:0]   reg2_addr_o,
	output logic [`REG_ADDR_W-1:0]   wd_o,
	output logic                     wreg_o,
	output decode_pkg::alu_op_e      aluop_o,
	output decode_pkg::alu_sel_e     alusel_o,
	output logic [`DATA_W-1:0]       imm_o,
	output decode_pkg::branch_kind_e branch_kind_o,
	output logic                     link_o
);

	import decode_pkg::*;

	opcode_e op;
	funct_e  fn;
	regimm_e ri;

	logic [`REG_ADDR_W-1:0] rs;
	logic [`REG_ADDR_W-1:0] rt;
	logic [`REG_ADDR_W-1:0] rd;

	logic [`DATA_W-1:0] imm_zext;
	logic [`DATA_W-1:0] imm_sext;
	logic [`DATA_W-1:0] imm_lui;
	logic [`DATA_W-1:0] imm_shamt;

	// set by the immediate ALU forms, which share rs read and rt write
	logic itype;

	assign op = opcode_e'(inst_i[31:26]);
	assign fn = funct_e'(inst_i[5:0]);
	assign ri = regimm_e'(inst_i[20:16]);

	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];

	assign imm_zext  = {{(`DATA_W-16){1'b0}}, inst_i[15:0]};
	assign imm_sext  = {{(`DATA_W-16){inst_i[15]}}, inst_i[15:0]};
	assign imm_lui   = {inst_i[15:0], {(`DATA_W-16){1'b0}}};
	assign imm_shamt = {{(`DATA_W-5){1'b0}}, inst_i[10:6]};

	always_comb begin
		reg1_read_o   = 1'b0;
		reg2_read_o   = 1'b0;
		reg1_addr_o   = '0;
		reg2_addr_o   = '0;
		wd_o          = '0;
		wreg_o        = 1'b0;
		aluop_o       = ALU_NOP;
		alusel_o      = SEL_NOP;
		imm_o         = '0;
		branch_kind_o = BR_NONE;
		link_o        = 1'b0;
		itype         = 1'b0;
		if (!rst_i) begin
			reg1_addr_o = rs;
			reg2_addr_o = rt;
			wd_o        = rd;
			case (op)
				OP_SPECIAL: begin
					// R-type reads both and writes rd unless overridden
					wreg_o      = 1'b1;
					reg1_read_o = 1'b1;
					reg2_read_o = 1'b1;
					case (fn)
						FN_AND: {aluop_o, alusel_o} = {ALU_AND, SEL_LOGIC};
						FN_OR: {aluop_o, alusel_o} = {ALU_OR, SEL_LOGIC};
						FN_XOR: {aluop_o, alusel_o} = {ALU_XOR, SEL_LOGIC};
						FN_NOR: {aluop_o, alusel_o} = {ALU_NOR, SEL_LOGIC};
						FN_SLLV: {aluop_o, alusel_o} = {ALU_SLL, SEL_SHIFT};
						FN_SRLV: {aluop_o, alusel_o} = {ALU_SRL, SEL_SHIFT};
						FN_SRAV: {aluop_o, alusel_o} = {ALU_SRA, SEL_SHIFT};
						FN_ADD: {aluop_o, alusel_o} = {ALU_ADD, SEL_ARITH};
						FN_ADDU: {aluop_o, alusel_o} = {ALU_ADDU, SEL_ARITH};
						FN_SUB: {aluop_o, alusel_o} = {ALU_SUB, SEL_ARITH};
						FN_SUBU: {aluop_o, alusel_o} = {ALU_SUBU, SEL_ARITH};
						FN_SLT: {aluop_o, alusel_o} = {ALU_SLT, SEL_ARITH};
						FN_SLTU: {aluop_o, alusel_o} = {ALU_SLTU, SEL_ARITH};
						FN_SLL, FN_SRL, FN_SRA: begin
							// shamt goes out as operand 1, rt is shifted
							alusel_o    = SEL_SHIFT;
							reg1_read_o = 1'b0;
							imm_o       = imm_shamt;
							if (fn == FN_SLL) begin
								aluop_o = ALU_SLL;
							end else if (fn == FN_SRL) begin
								aluop_o = ALU_SRL;
							end else begin
								aluop_o = ALU_SRA;
							end
						end
						FN_JR, FN_JALR: begin
							alusel_o      = SEL_JUMP_BRANCH;
							reg2_read_o   = 1'b0;
							branch_kind_o = BR_ALWAYS_REG;
							// JALR links into rd, JR writes nothing
							link_o        = (fn == FN_JALR);
							wreg_o        = (fn == FN_JALR);
							aluop_o       = (fn == FN_JALR) ? ALU_JALR : ALU_JR;
						end
						default: begin
							wreg_o      = 1'b0;
							reg1_read_o = 1'b0;
							reg2_read_o = 1'b0;
						end
					endcase
				end
				OP_ANDI: {itype, aluop_o, alusel_o, imm_o} = {1'b1, ALU_AND, SEL_LOGIC, imm_zext};
				OP_ORI: {itype, aluop_o, alusel_o, imm_o} = {1'b1, ALU_OR, SEL_LOGIC, imm_zext};
				OP_XORI: {itype, aluop_o, alusel_o, imm_o} = {1'b1, ALU_XOR, SEL_LOGIC, imm_zext};
				// LUI is an OR of rs with the upper half immediate
				OP_LUI: {itype, aluop_o, alusel_o, imm_o} = {1'b1, ALU_OR, SEL_LOGIC, imm_lui};
				OP_ADDI: {itype, aluop_o, alusel_o, imm_o} = {1'b1, ALU_ADDI, SEL_ARITH, imm_sext};
				OP_ADDIU: {itype, aluop_o, alusel_o, imm_o} = {1'b1, ALU_ADDIU, SEL_ARITH, imm_sext};
				OP_SLTI: {itype, aluop_o, alusel_o, imm_o} = {1'b1, ALU_SLT, SEL_ARITH, imm_sext};
				OP_SLTIU: {itype, aluop_o, alusel_o, imm_o} = {1'b1, ALU_SLTU, SEL_ARITH, imm_sext};
				OP_J, OP_JAL: begin
					alusel_o      = SEL_JUMP_BRANCH;
					branch_kind_o = BR_ALWAYS_IMM;
					if (op == OP_JAL) begin
						aluop_o = ALU_JAL;
						wreg_o  = 1'b1;
						wd_o    = `LINK_REG;
						link_o  = 1'b1;
					end else begin
						aluop_o = ALU_J;
					end
				end
				OP_BEQ, OP_BNE: begin
					alusel_o      = SEL_JUMP_BRANCH;
					reg1_read_o   = 1'b1;
					reg2_read_o   = 1'b1;
					aluop_o       = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
					branch_kind_o = (op == OP_BEQ) ? BR_EQ : BR_NE;
				end
				OP_BLEZ, OP_BGTZ: begin
					alusel_o      = SEL_JUMP_BRANCH;
					reg1_read_o   = 1'b1;
					aluop_o       = (op == OP_BLEZ) ? ALU_BLEZ : ALU_BGTZ;
					branch_kind_o = (op == OP_BLEZ) ? BR_LEZ : BR_GTZ;
				end
				OP_REGIMM: begin
					alusel_o    = SEL_JUMP_BRANCH;
					reg1_read_o = 1'b1;
					case (ri)
						RI_BLTZ: {aluop_o, branch_kind_o} = {ALU_BLTZ, BR_LTZ};
						RI_BGEZ: {aluop_o, branch_kind_o} = {ALU_BGEZ, BR_GEZ};
						RI_BLTZAL: {aluop_o, branch_kind_o} = {ALU_BLTZAL, BR_LTZ};
						RI_BGEZAL: {aluop_o, branch_kind_o} = {ALU_BGEZAL, BR_GEZ};
						default: begin
							alusel_o    = SEL_NOP;
							reg1_read_o = 1'b0;
						end
					endcase
					// AL forms link to r31 whether or not taken
					if (ri == RI_BLTZAL || ri == RI_BGEZAL) begin
						wreg_o = 1'b1;
						wd_o   = `LINK_REG;
						link_o = 1'b1;
					end
				end
				default: begin
				end
			endcase
			if (itype) begin
				wreg_o      = 1'b1;
				reg1_read_o = 1'b1;
				wd_o        = rt;
			end
		end
	end

endmodule

// File: design/decode_pkg.sv
package decode_pkg;

	// primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	// function field under SPECIAL, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// rt field under REGIMM, inst[20:16]
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'b00000,
		RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001
	} regimm_e;

	// operation handed to execute
	typedef enum logic [7:0] {
		ALU_NOP    = 8'b00000000,
		ALU_AND    = 8'b00100100,
		ALU_OR     = 8'b00100101,
		ALU_XOR    = 8'b00100110,
		ALU_NOR    = 8'b00100111,
		ALU_SLL    = 8'b01111100,
		ALU_SRL    = 8'b00000010,
		ALU_SRA    = 8'b00000011,
		ALU_SLT    = 8'b00101010,
		ALU_SLTU   = 8'b00101011,
		ALU_ADD    = 8'b00100000,
		ALU_ADDU   = 8'b00100001,
		ALU_SUB    = 8'b00100010,
		ALU_SUBU   = 8'b00100011,
		ALU_ADDI   = 8'b01010101,
		ALU_ADDIU  = 8'b01010110,
		ALU_J      = 8'b01001111,
		ALU_JAL    = 8'b01010000,
		ALU_JR     = 8'b00001000,
		ALU_JALR   = 8'b00001001,
		ALU_BEQ    = 8'b01010001,
		ALU_BNE    = 8'b01010010,
		ALU_BLEZ   = 8'b01010011,
		ALU_BGTZ   = 8'b01010100,
		ALU_BLTZ   = 8'b01000000,
		ALU_BGEZ   = 8'b01000001,
		ALU_BLTZAL = 8'b01001010,
		ALU_BGEZAL = 8'b01001011
	} alu_op_e;

	// result class picked in execute
	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110
	} alu_sel_e;

	// nine conditions, so four bits
	typedef enum logic [3:0] {
		BR_NONE,
		BR_ALWAYS_IMM,
		BR_ALWAYS_REG,
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_GEZ,
		BR_LTZ
	} branch_kind_e;

endpackage

// File: include/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// data path and instruction address width
`define DATA_W 32

// register file address width
`define REG_ADDR_W 5

// destination of JAL, BGEZAL and BLTZAL
// keep the literal width equal to REG_ADDR_W
`define LINK_REG 5'd31

`endif
